// File: all.f
+incdir+.
rv_isa_pkg.sv
core_pkg.sv
fetch_unit.sv
decoder.sv
register_file.sv
alu.sv
load_store_unit.sv
cpu_top.sv
tb_cpu_top.sv

// File: tb_tests.svh
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

// held beat during run must not land, rerun after reset repeats the trace
task automatic handshake_and_rerun();
    int          errors_before;
    logic [31:0] rnd;
    retire_t     first_q [$];
    errors_before = errors;
    rnd = next_random();
    program_q.delete();
    program_q.push_back(i_word(7'b0010011, 3'b000, 5'd1, 5'd0, rnd[11:0]));
    program_q.push_back(s_word(5'd0, 5'd1, 12'd16));
    program_q.push_back(i_word(7'b0000011, 3'b010, 5'd2, 5'd0, 12'd16));
    program_q.push_back(r_word(7'b0000000, 3'b000, 5'd3, 5'd1, 5'd2));
    program_q.push_back(lui_word(5'd4, rnd[31:12]));
    reset_dut();
    #sample_delay;
    compare_field("retire.valid", retire.valid, 32'd0);
    compare_field("prog_ready", prog_ready, 32'd1);
    load_program();
    execute_program(1'b1);
    first_q = trace_q;
    reset_dut();
    execute_program(1'b0);
    for (int k = 0; k < first_q.size(); k++) begin
        checks++;
        assert (trace_q[k] === first_q[k]) else begin
            $display("rerun record %0d differs from the first run", k);
            errors++;
        end
    end
    finish_test("handshake_and_rerun", errors_before);
endtask

task automatic immediate_ops();
    int          errors_before;
    logic [31:0] rnd;
    logic [31:0] value;
    logic [11:0] imm;
    logic [2:0]  f3_list [8] = '{3'b000, 3'b100, 3'b110, 3'b111,
                                 3'b010, 3'b001, 3'b101, 3'b101};
    errors_before = errors;
    program_q.delete();
    for (int i = 0; i < 8; i++) begin
        rnd   = next_random();
        value = next_random();
        // srai on a negative operand
        if (i == 7)
            value[31] = 1'b1;
        push_const(5'd1, value);
        if (f3_list[i] == 3'b001 || f3_list[i] == 3'b101)
            imm = {(i == 7) ? 7'b0100000 : 7'b0000000, rnd[4:0]};
        else
            imm = rnd[11:0];
        program_q.push_back(i_word(7'b0010011, f3_list[i], 5'(2 + i), 5'd1, imm));
    end
    load_and_run();
    finish_test("immediate_ops", errors_before);
endtask

task automatic register_ops();
    int          errors_before;
    logic [2:0]  f3_list [9] = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b100,
                                 3'b001, 3'b101, 3'b101, 3'b010};
    logic        alt_list [9] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
    errors_before = errors;
    program_q.delete();
    push_const(5'd1, next_random() | 32'h8000_0000);
    push_const(5'd2, next_random() & 32'h7fff_ffff);
    for (int i = 0; i < 9; i++) begin
        program_q.push_back(r_word(alt_list[i] ? 7'b0100000 : 7'b0000000, f3_list[i],
                                   5'(3 + i), 5'd1, 5'd2));
    end
    // slt the other way round
    program_q.push_back(r_word(7'b0000000, 3'b010, 5'd12, 5'd2, 5'd1));
    load_and_run();
    finish_test("register_ops", errors_before);
endtask

task automatic lui_and_x0();
    int          errors_before;
    logic [31:0] rnd;
    errors_before = errors;
    rnd = next_random();
    program_q.delete();
    program_q.push_back(lui_word(5'd5, rnd[31:12]));
    program_q.push_back(lui_word(5'd0, rnd[19:0]));
    program_q.push_back(i_word(7'b0010011, 3'b000, 5'd0, 5'd5, 12'd7));
    program_q.push_back(r_word(7'b0000000, 3'b000, 5'd6, 5'd0, 5'd5));
    program_q.push_back(i_word(7'b0010011, 3'b000, 5'd7, 5'd0, 12'd0));
    load_and_run();
    finish_test("lui_and_x0", errors_before);
endtask

task automatic store_then_load();
    int          errors_before;
    errors_before = errors;
    program_q.delete();
    program_q.push_back(i_word(7'b0010011, 3'b000, 5'd1, 5'd0, 12'h020));
    push_const(5'd2, next_random());
    push_const(5'd3, next_random());
    program_q.push_back(s_word(5'd1, 5'd2, 12'd4));
    program_q.push_back(s_word(5'd1, 5'd3, 12'hff8));
    program_q.push_back(i_word(7'b0000011, 3'b010, 5'd4, 5'd1, 12'd4));
    program_q.push_back(i_word(7'b0000011, 3'b010, 5'd5, 5'd1, 12'hff8));
    load_and_run();
    finish_test("store_then_load", errors_before);
endtask

task automatic zero_word_skip();
    int          errors_before;
    errors_before = errors;
    program_q.delete();
    program_q.push_back(i_word(7'b0010011, 3'b000, 5'd1, 5'd0, 12'd5));
    program_q.push_back(32'h0000_0000);
    program_q.push_back(i_word(7'b0010011, 3'b000, 5'd2, 5'd1, 12'd1));
    program_q.push_back(32'h0000_0000);
    program_q.push_back(r_word(7'b0000000, 3'b000, 5'd3, 5'd1, 5'd2));
    load_and_run();
    finish_test("zero_word_skip", errors_before);
endtask

`endif

// File: tb_cpu_top.sv
module tb_cpu_top;
    import rv_isa_pkg::*;
    import core_pkg::*;

    localparam int half_period  = 20;
    // retire is read in the low phase, after the falling-edge drive settles
    localparam int sample_delay = 10;
    // all tests together need a few hundred cycles
    localparam int max_cycles   = 1500;

    logic        clk;
    logic        reset;
    logic        run;
    prog_load_t  prog;
    logic        prog_ready;
    retire_t     retire;

    int          errors;
    int          checks;
    int          tests_done;
    int          cycles;
    logic [31:0] rng_state;
    logic [31:0] ref_regs [32];
    logic [31:0] ref_mem [32];
    logic [31:0] program_q [$];
    retire_t     trace_q [$];

    cpu_top #(
        .imem_depth(32),
        .dmem_depth(32)
    ) dut (
        .clk(clk),
        .reset(reset),
        .run(run),
        .prog(prog),
        .prog_ready(prog_ready),
        .retire(retire)
    );

    always #half_period clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles, a test never finished", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic logic [31:0] r_word(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                           logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_word(logic [6:0] opc, logic [2:0] f3, logic [4:0] rd,
                                           logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_word(logic [4:0] rs1, logic [4:0] rs2, logic [11:0] off);
        return {off[11:5], rs2, rs1, 3'b010, off[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] lui_word(logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    // lui then addi, upper part rounded up when the low 12 bits are negative
    task automatic push_const(logic [4:0] rd, logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;
        program_q.push_back(lui_word(rd, upper[31:12]));
        program_q.push_back(i_word(7'b0010011, 3'b000, rd, rd, value[11:0]));
    endtask

    function automatic logic [31:0] alu_model(logic [2:0] f3, logic alt, logic [31:0] a,
                                              logic [31:0] b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return {31'b0, $signed(a) < $signed(b)};
            3'b100: return a ^ b;
            3'b101: begin
                if (alt)
                    return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    // executes one word on the reference state
    task automatic model_step(input logic [31:0] w, output logic valid, output logic we,
                              output logic [31:0] value);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] addr;
        a     = ref_regs[w[19:15]];
        b     = ref_regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        valid = 1'b1;
        we    = 1'b0;
        value = '0;
        case (w[6:0])
            7'b0110011: begin
                value = alu_model(w[14:12], w[30], a, b);
                we    = 1'b1;
            end
            7'b0010011: begin
                value = alu_model(w[14:12], w[30] && w[14:12] == 3'b101, a, imm_i);
                we    = 1'b1;
            end
            7'b0110111: begin
                value = {w[31:12], 12'b0};
                we    = 1'b1;
            end
            7'b0000011: begin
                addr  = a + imm_i;
                value = ref_mem[addr[6:2]];
                we    = 1'b1;
            end
            7'b0100011: begin
                addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                ref_mem[addr[6:2]] = b;
            end
            default: valid = 1'b0;
        endcase
        we = we && w[11:7] != 5'd0;
        if (we)
            ref_regs[w[11:7]] = value;
    endtask

    task automatic compare_field(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH time %0t %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic reset_dut();
        @(negedge clk);
        reset = 1'b1;
        run   = 1'b0;
        prog  = '0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        foreach (ref_regs[i])
            ref_regs[i] = '0;
    endtask

    task automatic load_program();
        for (int i = 0; i < program_q.size(); i++) begin
            @(negedge clk);
            prog.valid = 1'b1;
            prog.addr  = 16'(i);
            prog.word  = program_q[i];
            @(posedge clk);
            while (!prog_ready)
                @(posedge clk);
        end
        @(negedge clk);
        prog = '0;
    endtask

    // one retire per cycle, each checked against the model
    task automatic execute_program(bit hold_beat);
        logic        exp_valid;
        logic        exp_we;
        logic [31:0] exp_value;
        @(negedge clk);
        run = 1'b1;
        if (hold_beat)
            prog = '{valid: 1'b1, addr: 16'd0, word: 32'h0};
        trace_q.delete();
        for (int k = 0; k < program_q.size(); k++) begin
            if (k > 0)
                @(negedge clk);
            #sample_delay;
            model_step(program_q[k], exp_valid, exp_we, exp_value);
            compare_field("prog_ready", prog_ready, 32'd0);
            compare_field("retire.valid", retire.valid, exp_valid);
            compare_field("retire.pc", retire.pc, 32'(4 * k));
            compare_field("retire.instr", retire.instr, program_q[k]);
            compare_field("retire.we", retire.we, exp_we);
            if (exp_we) begin
                compare_field("retire.rd", retire.rd, program_q[k][11:7]);
                compare_field("retire.value", retire.value, exp_value);
            end
            trace_q.push_back(retire);
        end
        @(negedge clk);
        run  = 1'b0;
        prog = '0;
    endtask

    task automatic load_and_run();
        reset_dut();
        load_program();
        execute_program(1'b0);
    endtask

    task automatic finish_test(string name, int errors_before);
        tests_done++;
        if (errors == errors_before)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errors - errors_before);
    endtask

    `include "tb_tests.svh"

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        run        = 1'b0;
        prog       = '0;
        errors     = 0;
        checks     = 0;
        tests_done = 0;
        cycles     = 0;
        rng_state  = 32'd16194;
        handshake_and_rerun();
        immediate_ops();
        register_ops();
        lui_and_x0();
        store_then_load();
        zero_word_skip();
        $display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: cpu_top.sv
module cpu_top #(
    parameter int imem_depth = 32,
    parameter int dmem_depth = 32
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 run,
    input  core_pkg::prog_load_t prog,
    output logic                 prog_ready,
    output core_pkg::retire_t    retire
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    logic [xlen-1:0] pc;
    instr_t          instr;
    ctrl_t           ctrl;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] wb_data;
    logic            reg_we;

    fetch_unit #(
        .imem_depth(imem_depth)
    ) u_fetch (
        .clk(clk),
        .reset(reset),
        .run(run),
        .prog(prog),
        .prog_ready(prog_ready),
        .pc(pc),
        .instr(instr)
    );

    decoder u_decoder (
        .instr(instr),
        .ctrl(ctrl)
    );

    register_file u_regs (
        .clk(clk),
        .reset(reset),
        .rs1(ctrl.rs1),
        .rs2(ctrl.rs2),
        .rd(ctrl.rd),
        .we(reg_we),
        .wdata(wb_data),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data)
    );

    alu u_alu (
        .ctrl(ctrl),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .result(alu_result)
    );

    load_store_unit #(
        .dmem_depth(dmem_depth)
    ) u_lsu (
        .clk(clk),
        .run(run),
        .pc(pc),
        .instr(instr),
        .ctrl(ctrl),
        .alu_result(alu_result),
        .rs2_data(rs2_data),
        .wb_data(wb_data),
        .reg_we(reg_we),
        .retire(retire)
    );

endmodule

// File: load_store_unit.sv
module load_store_unit #(
    parameter int dmem_depth = 32
) (
    input  logic                         clk,
    input  logic                         run,
    input  logic [rv_isa_pkg::xlen-1:0]  pc,
    input  rv_isa_pkg::instr_t           instr,
    input  core_pkg::ctrl_t              ctrl,
    input  logic [rv_isa_pkg::xlen-1:0]  alu_result,
    input  logic [rv_isa_pkg::xlen-1:0]  rs2_data,
    output logic [rv_isa_pkg::xlen-1:0]  wb_data,
    output logic                         reg_we,
    output core_pkg::retire_t            retire
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    localparam int idx_w = $clog2(dmem_depth);

    logic [xlen-1:0]  dmem [dmem_depth];
    logic [idx_w-1:0] word_idx;
    logic [xlen-1:0]  load_data;

    // drop the byte offset
    assign word_idx = alu_result[idx_w+1:2];

    always_ff @(posedge clk) begin
        if (run && ctrl.mem_write) begin
            dmem[word_idx] <= rs2_data;
        end
    end

    assign load_data = dmem[word_idx];
    assign wb_data   = ctrl.mem_read ? load_data : alu_result;
    assign reg_we    = run && ctrl.reg_write;

    always_comb begin
        retire.valid = run && ctrl.legal;
        retire.pc    = pc;
        retire.instr = instr;
        retire.we    = reg_we && (ctrl.rd != '0);
        retire.rd    = ctrl.rd;
        retire.value = wb_data;
    end

    // word accesses only, base register plus offset must be aligned
    assert property (@(posedge clk)
        run && (ctrl.mem_read || ctrl.mem_write) |-> alu_result[1:0] == 2'b00)
        else $error("misaligned access at pc %h", pc);

endmodule

// File: alu.sv
module alu (
    input  core_pkg::ctrl_t              ctrl,
    input  logic [rv_isa_pkg::xlen-1:0]  rs1_data,
    input  logic [rv_isa_pkg::xlen-1:0]  rs2_data,
    output logic [rv_isa_pkg::xlen-1:0]  result
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;

    assign op_b  = ctrl.use_imm ? ctrl.imm : rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            alu_add:    result = rs1_data + op_b;
            alu_sub:    result = rs1_data - op_b;
            alu_and:    result = rs1_data & op_b;
            alu_or:     result = rs1_data | op_b;
            alu_xor:    result = rs1_data ^ op_b;
            alu_sll:    result = rs1_data << shamt;
            alu_srl:    result = rs1_data >> shamt;
            alu_sra:    result = $signed(rs1_data) >>> shamt;
            // signed compare
            alu_slt:    result = {{(xlen-1){1'b0}}, $signed(rs1_data) < $signed(op_b)};
            alu_pass_b: result = op_b;
            default:    result = '0;
        endcase
    end

endmodule

// File: register_file.sv
module register_file (
    input  logic                         clk,
    input  logic                         reset,
    input  rv_isa_pkg::reg_addr_t        rs1,
    input  rv_isa_pkg::reg_addr_t        rs2,
    input  rv_isa_pkg::reg_addr_t        rd,
    input  logic                         we,
    input  logic [rv_isa_pkg::xlen-1:0]  wdata,
    output logic [rv_isa_pkg::xlen-1:0]  rs1_data,
    output logic [rv_isa_pkg::xlen-1:0]  rs2_data
);
    import rv_isa_pkg::*;

    // x0 has no storage
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    // a write shows on the next read of that index, except for x0
    assert property (@(posedge clk) disable iff (reset)
        we |=> (rs1 != $past(rd))
               || (rs1_data == (($past(rd) == '0) ? '0 : $past(wdata))))
        else $error("register x%0d read back wrong", rs1);

endmodule

// File: decoder.sv
module decoder (
    input  rv_isa_pkg::instr_t instr,
    output core_pkg::ctrl_t    ctrl
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_u;
    logic            is_reg;
    logic            alt;
    logic            funct7_ok;
    logic            funct_ok;
    alu_op_t         funct_alu;

    assign imm_i = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
    assign imm_s = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
    assign imm_u = {instr.u_fmt.imm, 12'b0};

    assign is_reg    = instr.r_fmt.opcode == op_reg;
    // funct7 picks sub in register form and sra in both forms
    assign alt       = instr.r_fmt.funct7 == f7_alt;
    assign funct7_ok = (instr.r_fmt.funct7 == f7_base) || alt;

    always_comb begin
        funct_ok = 1'b1;
        case (instr.r_fmt.funct3)
            f3_add_sub: funct_alu = (alt && is_reg) ? alu_sub : alu_add;
            f3_sll:     funct_alu = alu_sll;
            f3_slt:     funct_alu = alu_slt;
            f3_xor:     funct_alu = alu_xor;
            f3_srl_sra: funct_alu = alt ? alu_sra : alu_srl;
            f3_or:      funct_alu = alu_or;
            f3_and:     funct_alu = alu_and;
            default: begin
                // sltu is not supported
                funct_alu = alu_add;
                funct_ok  = 1'b0;
            end
        endcase
    end

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = alu_add;
        ctrl.rd     = instr.r_fmt.rd;
        ctrl.rs1    = instr.r_fmt.rs1;
        ctrl.rs2    = instr.r_fmt.rs2;
        case (instr.r_fmt.opcode)
            op_reg: begin
                ctrl.alu_op    = funct_alu;
                ctrl.legal     = funct_ok && funct7_ok;
                ctrl.reg_write = funct_ok && funct7_ok;
            end
            op_imm: begin
                ctrl.alu_op    = funct_alu;
                ctrl.use_imm   = 1'b1;
                ctrl.imm       = imm_i;
                ctrl.legal     = funct_ok;
                ctrl.reg_write = funct_ok;
            end
            op_lui: begin
                ctrl.alu_op    = alu_pass_b;
                ctrl.use_imm   = 1'b1;
                ctrl.imm       = imm_u;
                ctrl.legal     = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            op_load: begin
                ctrl.use_imm = 1'b1;
                ctrl.imm     = imm_i;
                if (instr.i_fmt.funct3 == f3_word) begin
                    ctrl.legal     = 1'b1;
                    ctrl.reg_write = 1'b1;
                    ctrl.mem_read  = 1'b1;
                end
            end
            op_store: begin
                ctrl.use_imm = 1'b1;
                ctrl.imm     = imm_s;
                if (instr.s_fmt.funct3 == f3_word) begin
                    ctrl.legal     = 1'b1;
                    ctrl.mem_write = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// File: fetch_unit.sv
module fetch_unit #(
    parameter int imem_depth = 32
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         run,
    input  core_pkg::prog_load_t         prog,
    output logic                         prog_ready,
    output logic [rv_isa_pkg::xlen-1:0]  pc,
    output rv_isa_pkg::instr_t           instr
);
    import rv_isa_pkg::*;

    localparam int idx_w = $clog2(imem_depth);

    logic [xlen-1:0] imem [imem_depth];
    logic            imem_we;

    // program loads only while the core is stopped
    assign prog_ready = !run;
    // out-of-range beats are accepted and dropped
    assign imem_we = prog.valid && prog_ready && (prog.addr < imem_depth);

    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[prog.addr[idx_w-1:0]] <= prog.word;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (run) begin
            // wrap at the end of the instruction array
            if (pc[xlen-1:2] == imem_depth - 1) begin
                pc <= '0;
            end else begin
                pc <= pc + 4;
            end
        end
    end

    assign instr = imem[pc[idx_w+1:2]];

    // a beat offered while running leaves the stored word untouched
    assert property (@(posedge clk) disable iff (reset)
        run && prog.valid && (prog.addr < imem_depth)
        |=> imem[$past(prog.addr[idx_w-1:0])] === $past(imem[prog.addr[idx_w-1:0]]))
        else $error("instruction memory written while running");

endmodule

// File: core_pkg.sv
package core_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_pass_b
    } alu_op_t;

    // decoded control for one instruction
    typedef struct packed {
        alu_op_t                      alu_op;
        logic                         use_imm;
        logic                         reg_write;
        logic                         mem_read;
        logic                         mem_write;
        logic                         legal;
        rv_isa_pkg::reg_addr_t        rd;
        rv_isa_pkg::reg_addr_t        rs1;
        rv_isa_pkg::reg_addr_t        rs2;
        logic [rv_isa_pkg::xlen-1:0]  imm;
    } ctrl_t;

    typedef struct packed {
        logic                         valid;
        logic [rv_isa_pkg::xlen-1:0]  pc;
        logic [31:0]                  instr;
        logic                         we;
        rv_isa_pkg::reg_addr_t        rd;
        logic [rv_isa_pkg::xlen-1:0]  value;
    } retire_t;

    // addr is a word index
    typedef struct packed {
        logic        valid;
        logic [15:0] addr;
        logic [31:0] word;
    } prog_load_t;

endpackage

// File: rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int xlen = 32;

    typedef logic [4:0] reg_addr_t;

    // base opcodes kept by this core
    typedef enum logic [6:0] {
        op_reg   = 7'b0110011,
        op_imm   = 7'b0010011,
        op_lui   = 7'b0110111,
        op_load  = 7'b0000011,
        op_store = 7'b0100011
    } opcode_t;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    // lw and sw
    localparam logic [2:0] f3_word    = 3'b010;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // store offset is split around rs2/rs1
    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        u_fmt_t u_fmt;
    } instr_t;

endpackage
